/* flist.f */
+incdir+dv
common/gpio_pkg.sv
hw/gpio_regs/gpio_regs.sv
hw/gpio_irq/gpio_irq.sv
hw/gpio_rd_mux.sv
hw/gpio_top.sv
dv/tb_gpio.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the GPIO peripheral testbench
set -e

cd "$(dirname "$0")"

TOP=tb_gpio
OBJ=obj_dir
LOG=sim.log

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert \
  --timescale 1ns/1ns \
  -f flist.f \
  --top-module "$TOP" \
  --Mdir "$OBJ" \
  -o "$TOP"

"./$OBJ/$TOP" | tee "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation passed"

/* dv/tb_gpio_tasks.svh */
// GPIO testbench bus tasks and tests
`ifndef TB_GPIO_TASKS_SVH
`define TB_GPIO_TASKS_SVH

function automatic logic [gpio_pkg::ADDR_BITS-1:0] word_addr(input int word);
  logic [gpio_pkg::ADDR_BITS-1:0] a;
  logic [31:0]                    r;
  r = $urandom;
  a = '0;
  a[gpio_pkg::ADDR_BITS-1:gpio_pkg::WORD_LSB] = word[gpio_pkg::WORD_BITS-1:0];
  a[gpio_pkg::WORD_LSB-1:0] = r[gpio_pkg::WORD_LSB-1:0];  // byte offset is ignored
  return a;
endfunction

function automatic logic [gpio_pkg::GPIO_WIDTH-1:0] rand_pins();
  logic [31:0] r;
  r = $urandom;
  return r[gpio_pkg::GPIO_WIDTH-1:0];
endfunction

function automatic logic [63:0] expect_word(input logic [gpio_pkg::ADDR_BITS-1:0] addr);
  logic [63:0] w;
  w = '0;
  case (addr[gpio_pkg::ADDR_BITS-1:gpio_pkg::WORD_LSB])
    gpio_pkg::WORD_DIR: begin
      w[gpio_pkg::GPIO_WIDTH-1:0]  = dir_m;
      w[32 +: gpio_pkg::GPIO_WIDTH] = in_m;
    end
    gpio_pkg::WORD_OUT: begin
      w[gpio_pkg::GPIO_WIDTH-1:0] = out_m;
      w[63:32] = scratch_m;
    end
    gpio_pkg::WORD_IRQ: begin
      w[gpio_pkg::GPIO_WIDTH-1:0]  = ie_m;
      w[32 +: gpio_pkg::GPIO_WIDTH] = pend_m;
    end
    default: w = '0;  // unmapped
  endcase
  return w;
endfunction

task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
  value_ok: assert (act === exp) else begin
    check_errs = check_errs + 1;
    $display("** Error %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic apply_write(input logic [gpio_pkg::ADDR_BITS-1:0] addr,
                           input logic [63:0] data, input logic [7:0] strb);
  logic lo;
  logic hi;
  lo = |strb[3:0];
  hi = |strb[7:4];
  case (addr[gpio_pkg::ADDR_BITS-1:gpio_pkg::WORD_LSB])
    gpio_pkg::WORD_DIR: if (lo) dir_m = data[gpio_pkg::GPIO_WIDTH-1:0];
    gpio_pkg::WORD_OUT: begin
      if (lo) out_m = data[gpio_pkg::GPIO_WIDTH-1:0];
      if (hi) scratch_m = data[63:32];
    end
    gpio_pkg::WORD_IRQ: begin
      if (lo) ie_m = data[gpio_pkg::GPIO_WIDTH-1:0];
      if (hi) pend_m = pend_m & ~data[32 +: gpio_pkg::GPIO_WIDTH];  // w1c
    end
    default: ;
  endcase
endtask

task automatic drive_req(input logic wr, input logic [gpio_pkg::ADDR_BITS-1:0] addr,
                         input logic [63:0] data, input logic [7:0] strb);
  i_req_valid = 1'b1;
  i_req_write = wr;
  i_req_addr  = addr;
  i_req_wdata = data;
  i_req_wstrb = strb;
endtask

task automatic idle_req();
  i_req_valid = 1'b0;
  i_req_write = 1'b0;
  i_req_addr  = '0;
  i_req_wdata = '0;
  i_req_wstrb = '0;
endtask

task automatic wait_resp(output logic [63:0] rdata);
  int n;
  n = 0;
  @(negedge clk);
  while (!o_resp_valid && n < 3) begin
    n++;
    @(negedge clk);
  end
  if (!o_resp_valid) begin
    check_errs = check_errs + 1;
    $display("no bus response within 4 cycles at %0t", $time);
  end
  rdata = o_resp_rdata;
endtask

// starts and ends 2 ns after a rising edge
task automatic bus_access(input logic wr, input logic [gpio_pkg::ADDR_BITS-1:0] addr,
                          input logic [63:0] data, input logic [7:0] strb,
                          output logic [63:0] rdata);
  drive_req(wr, addr, data, strb);
  @(posedge clk);
  #DRIVE_SKEW;
  idle_req();
  if (wr) apply_write(addr, data, strb);
  wait_resp(rdata);
  @(posedge clk);
  #DRIVE_SKEW;
  if (wr) check_val("write response data", 64'h0, rdata);
endtask

task automatic bus_write(input logic [gpio_pkg::ADDR_BITS-1:0] addr,
                         input logic [63:0] data, input logic [7:0] strb);
  logic [63:0] rd;
  bus_access(1'b1, addr, data, strb, rd);
endtask

task automatic read_check(input string name, input logic [gpio_pkg::ADDR_BITS-1:0] addr);
  logic [63:0] rd;
  bus_access(1'b0, addr, 64'h0, 8'h0, rd);
  check_val(name, expect_word(addr), rd);
endtask

task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk);
  #DRIVE_SKEW;
endtask

task automatic reset_values();
  check_val("reset o_resp_valid", 64'h0, 64'(o_resp_valid));
  check_val("reset o_irq", 64'h0, 64'(o_irq));
  check_val("reset o_gpio", 64'h0, 64'(o_gpio));
  check_val("reset o_gpio_dir", 64'hfff, 64'(o_gpio_dir));
  read_check("reset word 0", word_addr(0));
  read_check("reset word 1", word_addr(1));
  read_check("reset word 2", word_addr(2));
endtask

task automatic lane_writes();
  logic [gpio_pkg::ADDR_BITS-1:0] addr;
  logic [63:0]                    data;
  logic [7:0]                     strb;
  int                             i;
  for (i = 0; i < 20; i++) begin
    addr = word_addr(i % 2);
    data = {$urandom, $urandom};
    strb = 8'($urandom) | 8'h11;
    case ((i / 2) % 4)
      1: strb[7:4] = 4'h0;  // low lane only
      2: strb[3:0] = 4'h0;  // high lane only
      3: strb = 8'h00;      // neither lane
      default: ;
    endcase
    bus_write(addr, data, strb);
    check_val("lanes o_gpio", 64'(out_m), 64'(o_gpio));
    check_val("lanes o_gpio_dir", 64'(dir_m), 64'(o_gpio_dir));
    read_check("lanes readback", addr);
  end
endtask

task automatic input_sync();
  int i;
  for (i = 0; i < 8; i++) begin
    in_m   = rand_pins();
    i_gpio = in_m;
    wait_cycles(5);
    read_check("input sync word 0", word_addr(0));
  end
endtask

task automatic edge_irqs();
  logic [gpio_pkg::GPIO_WIDTH-1:0] pins;
  logic [63:0]                     rd;
  int                              i;
  i_gpio = '0;
  in_m   = '0;
  wait_cycles(5);
  bus_write(word_addr(2), 64'hffff_ffff_0000_0000, 8'hf0);  // drop stale pending
  read_check("irq clear stale", word_addr(2));
  pins    = rand_pins();
  pins[0] = 1'b1;   // always one input
  pins[1] = 1'b0;   // and one output
  bus_write(word_addr(0), 64'(pins), 8'h0f);
  pins    = rand_pins();
  pins[0] = 1'b1;
  bus_write(word_addr(2), 64'(pins), 8'h0f);
  for (i = 0; i < 6; i++) begin
    pins    = rand_pins();
    pins[0] = i[0];   // toggles so it rises every other pass
    pins[1] = i[0];
    pend_m  = pend_m | (pins & ~in_m & dir_m);
    in_m    = pins;
    i_gpio  = pins;
    wait_cycles(5);
    bus_access(1'b0, word_addr(2), 64'h0, 8'h0, rd);
    check_val("irq pending word", expect_word(word_addr(2)), rd);
    check_val("irq output pins", 64'h0, 64'(rd[32 +: gpio_pkg::GPIO_WIDTH] & ~dir_m));
    check_val("irq o_irq", 64'(pend_m & ie_m), 64'(o_irq));
  end
endtask

task automatic pending_clear();
  logic [gpio_pkg::GPIO_WIDTH-1:0] clr;
  int                              i;
  i_gpio = '0;
  in_m   = '0;
  wait_cycles(5);
  pend_m = pend_m | dir_m;  // every input pin rises
  in_m   = '1;
  i_gpio = '1;
  wait_cycles(5);
  bus_write(word_addr(2), 64'hfff, 8'h0f);
  for (i = 0; i < 4; i++) begin
    clr = rand_pins();
    bus_write(word_addr(2), 64'(clr) << 32, 8'hf0);
    check_val("w1c o_irq", 64'(pend_m & ie_m), 64'(o_irq));
    read_check("w1c pending word", word_addr(2));
  end
  bus_write(word_addr(2), 64'hffff_ffff_0000_0000, 8'hf0);
  check_val("w1c o_irq all clear", 64'h0, 64'(o_irq));
  read_check("w1c all clear", word_addr(2));
endtask

task automatic unmapped_and_b2b();
  logic                           op_wr[8];
  int                             op_word[8];
  logic [gpio_pkg::ADDR_BITS-1:0] op_addr[8];
  logic [63:0]                    op_data[8];
  int                             w;
  int                             i;
  for (i = 0; i < 4; i++) begin
    w = (i < 3) ? 3 + i : 6 + int'($urandom % 506);
    bus_write(word_addr(w), {$urandom, $urandom}, 8'hff);
    read_check("unmapped read", word_addr(w));
  end
  read_check("unmapped word 0", word_addr(0));
  read_check("unmapped word 1", word_addr(1));
  read_check("unmapped word 2", word_addr(2));

  op_wr   = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  op_word = '{1, 1, 0, 0, 2, 3, 3, 1};
  for (i = 0; i < 8; i++) begin
    op_addr[i] = word_addr(op_word[i]);
    op_data[i] = {$urandom, $urandom};
  end
  // one request per cycle, response for the previous one checked mid-cycle
  for (i = 0; i <= 8; i++) begin
    if (i < 8) drive_req(op_wr[i], op_addr[i], op_data[i], 8'hff);
    else idle_req();
    if (i > 0 && op_wr[i-1]) apply_write(op_addr[i-1], op_data[i-1], 8'hff);
    @(negedge clk);
    if (i > 0) begin
      check_val("b2b response valid", 64'h1, 64'(o_resp_valid));
      if (op_wr[i-1]) check_val("b2b write data", 64'h0, o_resp_rdata);
      else check_val("b2b read data", expect_word(op_addr[i-1]), o_resp_rdata);
    end
    @(posedge clk);
    #DRIVE_SKEW;
  end
endtask

`endif

/* dv/tb_gpio.sv */
// GPIO peripheral testbench
`timescale 1ns/1ns

module tb_gpio;

  localparam int CLK_HALF   = 10;
  localparam int DRIVE_SKEW = 2;
  localparam logic [31:0] SEED = 32'h9db3bea6;

  // rough cycle cost of each test
  localparam int LEN_RESET = 20;
  localparam int LEN_LANES = 80;
  localparam int LEN_INPUT = 64;
  localparam int LEN_IRQ   = 96;
  localparam int LEN_W1C   = 60;
  localparam int LEN_B2B   = 80;
  localparam int TEST_CYCLES =
    LEN_RESET + LEN_LANES + LEN_INPUT + LEN_IRQ + LEN_W1C + LEN_B2B;
  localparam int WATCHDOG_CYCLES = 5 * TEST_CYCLES;  // 2000 cycles

  logic                            clk;
  logic                            nrst;
  logic                            i_req_valid;
  logic                            i_req_write;
  logic [gpio_pkg::ADDR_BITS-1:0]  i_req_addr;
  logic [gpio_pkg::DATA_BITS-1:0]  i_req_wdata;
  logic [gpio_pkg::STRB_BITS-1:0]  i_req_wstrb;
  logic [gpio_pkg::GPIO_WIDTH-1:0] i_gpio;
  logic                            o_resp_valid;
  logic [gpio_pkg::DATA_BITS-1:0]  o_resp_rdata;
  logic [gpio_pkg::GPIO_WIDTH-1:0] o_gpio;
  logic [gpio_pkg::GPIO_WIDTH-1:0] o_gpio_dir;
  logic [gpio_pkg::GPIO_WIDTH-1:0] o_irq;

  int check_errs  = 0;
  int assert_errs = 0;

  // register model
  logic [gpio_pkg::GPIO_WIDTH-1:0] dir_m;
  logic [gpio_pkg::GPIO_WIDTH-1:0] out_m;
  logic [gpio_pkg::GPIO_WIDTH-1:0] ie_m;
  logic [gpio_pkg::GPIO_WIDTH-1:0] pend_m;
  logic [gpio_pkg::GPIO_WIDTH-1:0] in_m;   // settled pin value
  logic [31:0]                     scratch_m;

  gpio_top gpio_top_i (
    .clk          (clk),
    .nrst         (nrst),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_addr   (i_req_addr),
    .i_req_wdata  (i_req_wdata),
    .i_req_wstrb  (i_req_wstrb),
    .i_gpio       (i_gpio),
    .o_resp_valid (o_resp_valid),
    .o_resp_rdata (o_resp_rdata),
    .o_gpio       (o_gpio),
    .o_gpio_dir   (o_gpio_dir),
    .o_irq        (o_irq)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // sampled mid-cycle, away from both edges
  resp_follows_req: assert property (@(negedge clk) disable iff (!nrst)
      i_req_valid |=> o_resp_valid)
    else begin
      assert_errs = assert_errs + 1;
      $display("no response one cycle after a request at %0t", $time);
    end

  resp_needs_req: assert property (@(negedge clk) disable iff (!nrst)
      !i_req_valid |=> !o_resp_valid)
    else begin
      assert_errs = assert_errs + 1;
      $display("response without a request at %0t", $time);
    end

  // o_irq lags the enable register by one cycle
  irq_needs_enable: assert property (@(negedge clk) disable iff (!nrst)
      (o_irq & ~$past(ie_m)) == '0)
    else begin
      assert_errs = assert_errs + 1;
      $display("interrupt raised on a disabled pin at %0t", $time);
    end

  `include "tb_gpio_tasks.svh"

  initial begin
    void'($urandom(SEED));
    nrst        = 1'b0;
    i_req_valid = 1'b0;
    i_req_write = 1'b0;
    i_req_addr  = '0;
    i_req_wdata = '0;
    i_req_wstrb = '0;
    i_gpio      = '0;
    dir_m       = '1;   // all inputs
    out_m       = '0;
    ie_m        = '0;
    pend_m      = '0;
    in_m        = '0;
    scratch_m   = '0;
    repeat (5) @(posedge clk);
    #DRIVE_SKEW;
    nrst = 1'b1;

    reset_values();
    lane_writes();
    input_sync();
    edge_irqs();
    pending_clear();
    unmapped_and_b2b();

    repeat (2) @(posedge clk);
    $display("errors: %0d checks, %0d assertions", check_errs, assert_errs);
    if (check_errs + assert_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* hw/gpio_top.sv */
// GPIO peripheral top level
`timescale 1ns/1ns

module gpio_top (
  input  logic                             clk,
  input  logic                             nrst,
  input  logic                             i_req_valid,
  input  logic                             i_req_write,
  input  logic [gpio_pkg::ADDR_BITS-1:0]   i_req_addr,
  input  logic [gpio_pkg::DATA_BITS-1:0]   i_req_wdata,
  input  logic [gpio_pkg::STRB_BITS-1:0]   i_req_wstrb,
  input  logic [gpio_pkg::GPIO_WIDTH-1:0]  i_gpio,
  output logic                             o_resp_valid,
  output logic [gpio_pkg::DATA_BITS-1:0]   o_resp_rdata,
  output logic [gpio_pkg::GPIO_WIDTH-1:0]  o_gpio,
  output logic [gpio_pkg::GPIO_WIDTH-1:0]  o_gpio_dir,
  output logic [gpio_pkg::GPIO_WIDTH-1:0]  o_irq
);

  logic [gpio_pkg::GPIO_WIDTH-1:0] gpio_in_sync;
  logic [gpio_pkg::DATA_BITS-1:0]  dir_word;
  logic [gpio_pkg::DATA_BITS-1:0]  out_word;
  logic [gpio_pkg::DATA_BITS-1:0]  irq_word;
  logic [gpio_pkg::GPIO_WIDTH-1:0] irq_pend;

  gpio_regs regs_i (
    .clk            (clk),
    .nrst           (nrst),
    .i_req_valid    (i_req_valid),
    .i_req_write    (i_req_write),
    .i_req_addr     (i_req_addr),
    .i_req_wdata    (i_req_wdata),
    .i_req_wstrb    (i_req_wstrb),
    .i_gpio         (i_gpio),
    .o_gpio         (o_gpio),
    .o_gpio_dir     (o_gpio_dir),
    .o_gpio_in_sync (gpio_in_sync),
    .o_dir_word     (dir_word),
    .o_out_word     (out_word)
  );

  gpio_irq irq_i (
    .clk            (clk),
    .nrst           (nrst),
    .i_req_valid    (i_req_valid),
    .i_req_write    (i_req_write),
    .i_req_addr     (i_req_addr),
    .i_req_wdata    (i_req_wdata),
    .i_req_wstrb    (i_req_wstrb),
    .i_gpio_in_sync (gpio_in_sync),
    .i_gpio_dir     (o_gpio_dir),   // edges only count on inputs
    .o_irq_word     (irq_word),
    .o_irq_pend     (irq_pend)
  );

  gpio_rd_mux rd_mux_i (
    .clk          (clk),
    .nrst         (nrst),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_addr   (i_req_addr),
    .i_dir_word   (dir_word),
    .i_out_word   (out_word),
    .i_irq_word   (irq_word),
    .i_irq_pend   (irq_pend),
    .o_resp_valid (o_resp_valid),
    .o_resp_rdata (o_resp_rdata),
    .o_irq        (o_irq)
  );

endmodule

/* hw/gpio_rd_mux.sv */
// GPIO read data and response combiner
`timescale 1ns/1ns

module gpio_rd_mux (
  input  logic                             clk,
  input  logic                             nrst,
  input  logic                             i_req_valid,
  input  logic                             i_req_write,
  input  logic [gpio_pkg::ADDR_BITS-1:0]   i_req_addr,
  input  logic [gpio_pkg::DATA_BITS-1:0]   i_dir_word,
  input  logic [gpio_pkg::DATA_BITS-1:0]   i_out_word,
  input  logic [gpio_pkg::DATA_BITS-1:0]   i_irq_word,
  input  logic [gpio_pkg::GPIO_WIDTH-1:0]  i_irq_pend,
  output logic                             o_resp_valid,
  output logic [gpio_pkg::DATA_BITS-1:0]   o_resp_rdata,
  output logic [gpio_pkg::GPIO_WIDTH-1:0]  o_irq
);

  logic                           valid_q;
  logic                           write_q;
  logic [gpio_pkg::WORD_BITS-1:0] word_q;

  // capture the request for next-cycle response
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      valid_q <= 1'b0;
      write_q <= 1'b0;
      word_q  <= '0;
    end else begin
      valid_q <= i_req_valid;
      write_q <= i_req_write;
      word_q  <= i_req_addr[gpio_pkg::ADDR_BITS-1:gpio_pkg::WORD_LSB];
    end
  end

  always_comb begin
    o_resp_rdata = '0;  // writes and unmapped words
    if (valid_q && !write_q) begin
      case (word_q)
        gpio_pkg::WORD_DIR: o_resp_rdata = i_dir_word;
        gpio_pkg::WORD_OUT: o_resp_rdata = i_out_word;
        gpio_pkg::WORD_IRQ: o_resp_rdata = i_irq_word;
        default:            o_resp_rdata = '0;
      endcase
    end
  end

  assign o_resp_valid = valid_q;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      o_irq <= '0;
    end else begin
      o_irq <= i_irq_pend;
    end
  end

endmodule

/* hw/gpio_irq/gpio_irq.sv */
// GPIO edge interrupt unit
`timescale 1ns/1ns

module gpio_irq (
  input  logic                             clk,
  input  logic                             nrst,
  input  logic                             i_req_valid,
  input  logic                             i_req_write,
  input  logic [gpio_pkg::ADDR_BITS-1:0]   i_req_addr,
  input  logic [gpio_pkg::DATA_BITS-1:0]   i_req_wdata,
  input  logic [gpio_pkg::STRB_BITS-1:0]   i_req_wstrb,
  input  logic [gpio_pkg::GPIO_WIDTH-1:0]  i_gpio_in_sync,
  input  logic [gpio_pkg::GPIO_WIDTH-1:0]  i_gpio_dir,
  output logic [gpio_pkg::DATA_BITS-1:0]   o_irq_word,
  output logic [gpio_pkg::GPIO_WIDTH-1:0]  o_irq_pend
);

  logic [gpio_pkg::WORD_BITS-1:0]  word_idx;
  logic                            wr_irq;
  logic                            wr_ie;
  logic                            wr_clr;

  logic [gpio_pkg::GPIO_WIDTH-1:0] in_prev_q;
  logic [gpio_pkg::GPIO_WIDTH-1:0] rise;
  logic [gpio_pkg::GPIO_WIDTH-1:0] clr_mask;
  logic [gpio_pkg::GPIO_WIDTH-1:0] ie_q;
  logic [gpio_pkg::GPIO_WIDTH-1:0] pend_q;
  logic [gpio_pkg::GPIO_WIDTH-1:0] pend_next;

  assign word_idx = i_req_addr[gpio_pkg::ADDR_BITS-1:gpio_pkg::WORD_LSB];
  assign wr_irq   = i_req_valid & i_req_write & (word_idx == gpio_pkg::WORD_IRQ);

  // low lanes load enables, high lanes clear pending
  assign wr_ie  = wr_irq & (|i_req_wstrb[gpio_pkg::HALF_STRB-1:0]);
  assign wr_clr = wr_irq & (|i_req_wstrb[gpio_pkg::STRB_BITS-1:gpio_pkg::HALF_STRB]);

  // previous synced value for edge detect
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      in_prev_q <= '0;
    end else begin
      in_prev_q <= i_gpio_in_sync;
    end
  end

  // rising edges, input pins only
  assign rise = i_gpio_in_sync & ~in_prev_q & i_gpio_dir;

  always_comb begin
    clr_mask = '0;
    if (wr_clr) begin
      clr_mask = i_req_wdata[gpio_pkg::HALF_BITS +: gpio_pkg::GPIO_WIDTH];
    end
  end

  // a new edge beats a clear in the same cycle
  assign pend_next = (pend_q & ~clr_mask) | rise;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      ie_q <= '0;
    end else if (wr_ie) begin
      ie_q <= i_req_wdata[gpio_pkg::GPIO_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_next;  // sticky
    end
  end

  always_comb begin
    o_irq_word = '0;
    o_irq_word[gpio_pkg::GPIO_WIDTH-1:0] = ie_q;
    o_irq_word[gpio_pkg::HALF_BITS +: gpio_pkg::GPIO_WIDTH] = pend_q;
  end

  // only enabled pins raise an interrupt
  assign o_irq_pend = pend_q & ie_q;

endmodule

/* hw/gpio_regs/gpio_regs.sv */
// GPIO direction, output and scratch registers
`timescale 1ns/1ns

module gpio_regs (
  input  logic                             clk,
  input  logic                             nrst,
  input  logic                             i_req_valid,
  input  logic                             i_req_write,
  input  logic [gpio_pkg::ADDR_BITS-1:0]   i_req_addr,
  input  logic [gpio_pkg::DATA_BITS-1:0]   i_req_wdata,
  input  logic [gpio_pkg::STRB_BITS-1:0]   i_req_wstrb,
  input  logic [gpio_pkg::GPIO_WIDTH-1:0]  i_gpio,
  output logic [gpio_pkg::GPIO_WIDTH-1:0]  o_gpio,
  output logic [gpio_pkg::GPIO_WIDTH-1:0]  o_gpio_dir,
  output logic [gpio_pkg::GPIO_WIDTH-1:0]  o_gpio_in_sync,
  output logic [gpio_pkg::DATA_BITS-1:0]   o_dir_word,
  output logic [gpio_pkg::DATA_BITS-1:0]   o_out_word
);

  logic [gpio_pkg::WORD_BITS-1:0]  word_idx;
  logic                            wr_en;
  logic                            lane_lo;
  logic                            lane_hi;
  logic                            wr_dir;
  logic                            wr_out;
  logic                            wr_scratch;

  logic [gpio_pkg::GPIO_WIDTH-1:0] dir_q;
  logic [gpio_pkg::GPIO_WIDTH-1:0] out_q;
  logic [gpio_pkg::HALF_BITS-1:0]  scratch_q;
  logic [gpio_pkg::GPIO_WIDTH-1:0] in_meta_q;
  logic [gpio_pkg::GPIO_WIDTH-1:0] in_sync_q;

  assign word_idx = i_req_addr[gpio_pkg::ADDR_BITS-1:gpio_pkg::WORD_LSB];
  assign wr_en    = i_req_valid & i_req_write;

  // byte-lane qualification per 32-bit half
  assign lane_lo = |i_req_wstrb[gpio_pkg::HALF_STRB-1:0];
  assign lane_hi = |i_req_wstrb[gpio_pkg::STRB_BITS-1:gpio_pkg::HALF_STRB];

  assign wr_dir     = wr_en & lane_lo & (word_idx == gpio_pkg::WORD_DIR);
  assign wr_out     = wr_en & lane_lo & (word_idx == gpio_pkg::WORD_OUT);
  assign wr_scratch = wr_en & lane_hi & (word_idx == gpio_pkg::WORD_OUT);

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      dir_q     <= gpio_pkg::DIR_RESET;
      out_q     <= '0;
      scratch_q <= '0;
    end else begin
      if (wr_dir) begin
        dir_q <= i_req_wdata[gpio_pkg::GPIO_WIDTH-1:0];
      end
      if (wr_out) begin
        out_q <= i_req_wdata[gpio_pkg::GPIO_WIDTH-1:0];
      end
      if (wr_scratch) begin
        scratch_q <= i_req_wdata[gpio_pkg::DATA_BITS-1:gpio_pkg::HALF_BITS];
      end
    end
  end

  // two-flop synchronizer on the pins
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= i_gpio;
      in_sync_q <= in_meta_q;
    end
  end

  always_comb begin
    o_dir_word = '0;
    o_dir_word[gpio_pkg::GPIO_WIDTH-1:0] = dir_q;
    o_dir_word[gpio_pkg::HALF_BITS +: gpio_pkg::GPIO_WIDTH] = in_sync_q;  // read only
  end

  always_comb begin
    o_out_word = '0;
    o_out_word[gpio_pkg::GPIO_WIDTH-1:0] = out_q;
    o_out_word[gpio_pkg::DATA_BITS-1:gpio_pkg::HALF_BITS] = scratch_q;
  end

  assign o_gpio         = out_q;
  assign o_gpio_dir     = dir_q;
  assign o_gpio_in_sync = in_sync_q;

endmodule

/* common/gpio_pkg.sv */
// GPIO peripheral definitions
package gpio_pkg;

  // pin count
  localparam int GPIO_WIDTH = 12;

  // request bus sizes
  localparam int ADDR_BITS = 12;
  localparam int DATA_BITS = 64;
  localparam int STRB_BITS = 8;

  // each 64-bit word splits into two 32-bit lanes
  localparam int HALF_BITS = DATA_BITS / 2;
  localparam int HALF_STRB = STRB_BITS / 2;

  // word index is addr[11:3]
  localparam int WORD_LSB  = 3;
  localparam int WORD_BITS = ADDR_BITS - WORD_LSB;

  // direction in the low half, synced input (ro) in the high half
  localparam logic [WORD_BITS-1:0] WORD_DIR = 9'd0;
  // output value in the low half, scratch in the high half
  localparam logic [WORD_BITS-1:0] WORD_OUT = 9'd1;
  // irq enable in the low half, pending (w1c) in the high half
  localparam logic [WORD_BITS-1:0] WORD_IRQ = 9'd2;

  // all pins come up as inputs
  localparam logic [GPIO_WIDTH-1:0] DIR_RESET = '1;

endpackage
